/* hw/exec_pkg.sv */
package exec_pkg;

    // datapath widths
    localparam int xlen = 64;
    localparam int op_w = 5;
    localparam int sel_w = 2;
    localparam int shamt_w = $clog2(xlen);

    // iterative multiplier, one multiplier bit per step
    localparam int mul_steps = 64;
    localparam int mul_cnt_w = $clog2(mul_steps);
    localparam logic [mul_cnt_w-1:0] mul_last = mul_cnt_w'(mul_steps - 1);

    // arithmetic and pass-through
    localparam logic [op_w-1:0] op_add = 5'd0;
    localparam logic [op_w-1:0] op_sub = 5'd1;
    localparam logic [op_w-1:0] op_ret_a = 5'd2;
    localparam logic [op_w-1:0] op_ret_b = 5'd3;

    // logic
    localparam logic [op_w-1:0] op_xor = 5'd4;
    localparam logic [op_w-1:0] op_or = 5'd5;
    localparam logic [op_w-1:0] op_and = 5'd6;

    // shifts use the low bits of b
    localparam logic [op_w-1:0] op_sll = 5'd7;
    localparam logic [op_w-1:0] op_srl = 5'd8;
    localparam logic [op_w-1:0] op_sra = 5'd9;

    // compares return 0 or 1
    localparam logic [op_w-1:0] op_slt = 5'd10;
    localparam logic [op_w-1:0] op_sltu = 5'd11;
    localparam logic [op_w-1:0] op_eq = 5'd12;
    localparam logic [op_w-1:0] op_ge = 5'd13;
    localparam logic [op_w-1:0] op_geu = 5'd14;

    // low half of a*b, multi-cycle
    localparam logic [op_w-1:0] op_mul = 5'd15;

    // operand a: rs1, anything else is pc
    localparam logic [sel_w-1:0] sel_a_rs1 = 2'd1;

    // operand b: rs2 or csr, anything else is imm
    localparam logic [sel_w-1:0] sel_b_rs2 = 2'd1;
    localparam logic [sel_w-1:0] sel_b_csr = 2'd2;

endpackage

/* hw/exec_op_if.sv */
`timescale 1ns/1ps

interface exec_op_if;

    logic valid;
    logic ready;
    logic [exec_pkg::op_w-1:0] op;
    logic [exec_pkg::xlen-1:0] a;
    logic [exec_pkg::xlen-1:0] b;
    // rs1 was narrowed to 32 bits
    logic word;

    modport src (
        output valid,
        output op,
        output a,
        output b,
        output word,
        input ready
    );

    modport dst (
        input valid,
        input op,
        input a,
        input b,
        input word,
        output ready
    );

endinterface

/* hw/exec_mul_iter.sv */
`timescale 1ns/1ps

module exec_mul_iter (
    input logic clk,
    input logic rst_n,
    input logic flush,
    input logic start,
    input logic [exec_pkg::xlen-1:0] a,
    input logic [exec_pkg::xlen-1:0] b,
    output logic busy,
    output logic done,
    output logic [exec_pkg::xlen-1:0] product
);

    logic [exec_pkg::xlen-1:0] mcand;
    logic [exec_pkg::xlen-1:0] mplier;
    logic [exec_pkg::xlen-1:0] acc;
    logic [exec_pkg::mul_cnt_w-1:0] cnt;
    logic last;

    assign last = (cnt == exec_pkg::mul_last);
    assign product = acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt <= '0;
        end else if (flush) begin
            // abandon the product, no done
            busy <= 1'b0;
            done <= 1'b0;
            cnt <= '0;
        end else begin
            done <= busy && last;
            if (start && !busy) begin
                busy <= 1'b1;
                cnt <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // shift-add, bits above xlen fall off the multiplicand
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            mcand <= a;
            mplier <= b;
            acc <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

/* hw/exec_operand_sel.sv */
`timescale 1ns/1ps

module exec_operand_sel (
    input logic clk,
    input logic rst_n,
    input logic flush,
    input logic in_valid,
    output logic in_ready,
    input logic [exec_pkg::op_w-1:0] op,
    input logic [exec_pkg::sel_w-1:0] sel_a,
    input logic [exec_pkg::sel_w-1:0] sel_b,
    input logic word,
    input logic [exec_pkg::xlen-1:0] pc,
    input logic [exec_pkg::xlen-1:0] rs1,
    input logic [exec_pkg::xlen-1:0] rs2,
    input logic [exec_pkg::xlen-1:0] csr,
    input logic [exec_pkg::xlen-1:0] imm,
    exec_op_if.src o
);

    logic [exec_pkg::xlen-1:0] rs1_m;
    logic [exec_pkg::xlen-1:0] a_sel;
    logic [exec_pkg::xlen-1:0] b_sel;
    logic accept;

    // word mode keeps only the low half of rs1
    assign rs1_m = word ? {{(exec_pkg::xlen/2){1'b0}}, rs1[exec_pkg::xlen/2-1:0]} : rs1;

    assign a_sel = (sel_a == exec_pkg::sel_a_rs1) ? rs1_m : pc;
    assign b_sel = (sel_b == exec_pkg::sel_b_rs2) ? rs2 :
                   (sel_b == exec_pkg::sel_b_csr) ? csr : imm;

    // empty, or the held item moves on this cycle
    assign in_ready = !o.valid || o.ready;
    assign accept = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o.valid <= 1'b0;
        end else if (flush) begin
            o.valid <= 1'b0;
        end else if (in_ready) begin
            o.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o.op <= op;
            o.a <= a_sel;
            o.b <= b_sel;
            o.word <= word;
        end
    end

endmodule

/* hw/exec_alu.sv */
`timescale 1ns/1ps

module exec_alu (
    input logic clk,
    input logic rst_n,
    input logic flush,
    exec_op_if.dst i,
    output logic res_valid,
    input logic res_ready,
    output logic [exec_pkg::xlen-1:0] res_data
);

    logic is_mul;
    logic mul_idle;
    logic mul_start;
    logic mul_busy;
    logic mul_done;
    logic mul_hold;
    logic [exec_pkg::xlen-1:0] mul_product;
    logic [exec_pkg::xlen-1:0] alu_res;
    logic [exec_pkg::shamt_w-1:0] shamt;
    logic [exec_pkg::xlen/2-1:0] sra_w;

    assign shamt = i.b[exec_pkg::shamt_w-1:0];
    assign sra_w = $signed(i.a[exec_pkg::xlen/2-1:0]) >>> shamt;

    always_comb begin
        case (i.op)
            exec_pkg::op_add: alu_res = i.a + i.b;
            exec_pkg::op_sub: alu_res = i.a - i.b;
            exec_pkg::op_ret_a: alu_res = i.a;
            exec_pkg::op_ret_b: alu_res = i.b;
            exec_pkg::op_xor: alu_res = i.a ^ i.b;
            exec_pkg::op_or: alu_res = i.a | i.b;
            exec_pkg::op_and: alu_res = i.a & i.b;
            exec_pkg::op_sll: alu_res = i.a << shamt;
            exec_pkg::op_srl: alu_res = i.a >> shamt;
            exec_pkg::op_sra: begin
                // word form shifts the low half, then zero-extends
                if (i.word) begin
                    alu_res = {{(exec_pkg::xlen/2){1'b0}}, sra_w};
                end else begin
                    alu_res = $signed(i.a) >>> shamt;
                end
            end
            exec_pkg::op_slt: alu_res = {{(exec_pkg::xlen-1){1'b0}}, $signed(i.a) < $signed(i.b)};
            exec_pkg::op_sltu: alu_res = {{(exec_pkg::xlen-1){1'b0}}, i.a < i.b};
            exec_pkg::op_eq: alu_res = {{(exec_pkg::xlen-1){1'b0}}, i.a == i.b};
            exec_pkg::op_ge: alu_res = {{(exec_pkg::xlen-1){1'b0}}, $signed(i.a) >= $signed(i.b)};
            exec_pkg::op_geu: alu_res = {{(exec_pkg::xlen-1){1'b0}}, i.a >= i.b};
            default: alu_res = '0;
        endcase
    end

    // a multiply occupies the stage from start until its product leaves
    assign is_mul = (i.op == exec_pkg::op_mul);
    assign mul_idle = !mul_busy && !mul_done && !mul_hold;

    assign i.ready = mul_idle && (is_mul || res_ready);
    assign mul_start = i.valid && i.ready && is_mul;

    assign res_valid = mul_done || mul_hold || (mul_idle && i.valid && !is_mul);
    assign res_data = (mul_done || mul_hold) ? mul_product : alu_res;

    // product not taken at done waits here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_hold <= 1'b0;
        end else if (flush) begin
            mul_hold <= 1'b0;
        end else if (mul_done && !res_ready) begin
            mul_hold <= 1'b1;
        end else if (res_ready) begin
            mul_hold <= 1'b0;
        end
    end

    exec_mul_iter u_mul (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .start(mul_start),
        .a(i.a),
        .b(i.b),
        .busy(mul_busy),
        .done(mul_done),
        .product(mul_product)
    );

endmodule

/* hw/exec_result_buf.sv */
`timescale 1ns/1ps

module exec_result_buf (
    input logic clk,
    input logic rst_n,
    input logic flush,
    input logic res_valid,
    output logic res_ready,
    input logic [exec_pkg::xlen-1:0] res_data,
    output logic out_valid,
    input logic out_ready,
    output logic [exec_pkg::xlen-1:0] out_data
);

    assign res_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (res_ready) begin
            out_valid <= res_valid;
        end
    end

    // data only moves when the slot frees up
    always_ff @(posedge clk) begin
        if (res_valid && res_ready) begin
            out_data <= res_data;
        end
    end

endmodule

/* hw/exec_unit_top.sv */
`timescale 1ns/1ps

module exec_unit_top (
    input logic clk,
    input logic rst_n,
    input logic flush,
    input logic in_valid,
    output logic in_ready,
    input logic [exec_pkg::op_w-1:0] op,
    input logic [exec_pkg::sel_w-1:0] sel_a,
    input logic [exec_pkg::sel_w-1:0] sel_b,
    input logic word,
    input logic [exec_pkg::xlen-1:0] pc,
    input logic [exec_pkg::xlen-1:0] rs1,
    input logic [exec_pkg::xlen-1:0] rs2,
    input logic [exec_pkg::xlen-1:0] csr,
    input logic [exec_pkg::xlen-1:0] imm,
    output logic out_valid,
    input logic out_ready,
    output logic [exec_pkg::xlen-1:0] out_data
);

    logic res_valid;
    logic res_ready;
    logic [exec_pkg::xlen-1:0] res_data;

    // prepared operands into the alu
    exec_op_if u_op_if ();

    exec_operand_sel u_sel (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .op(op),
        .sel_a(sel_a),
        .sel_b(sel_b),
        .word(word),
        .pc(pc),
        .rs1(rs1),
        .rs2(rs2),
        .csr(csr),
        .imm(imm),
        .o(u_op_if.src)
    );

    exec_alu u_alu (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .i(u_op_if.dst),
        .res_valid(res_valid),
        .res_ready(res_ready),
        .res_data(res_data)
    );

    exec_result_buf u_buf (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .res_valid(res_valid),
        .res_ready(res_ready),
        .res_data(res_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_data)
    );

endmodule

/* sim/exec_checker.sv */
`timescale 1ns/1ps

module exec_checker (
    input logic clk,
    input logic rst_n,
    input logic flush,
    input logic in_ready,
    input logic out_valid,
    input logic out_ready,
    input logic [exec_pkg::xlen-1:0] out_data
);

    // held result stays put under back-pressure
    out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready && !flush |=> out_valid && $stable(out_data))
        else $error("out_valid or out_data changed while the consumer stalled");

    reset_state: assert property (@(posedge clk) !rst_n |-> in_ready && !out_valid)
        else $error("in_ready or out_valid wrong while in reset");

    release_state: assert property (@(posedge clk) $rose(rst_n) |-> in_ready && !out_valid)
        else $error("in_ready or out_valid wrong right after reset");

endmodule

bind exec_unit_top exec_checker u_checker (
    .clk(clk),
    .rst_n(rst_n),
    .flush(flush),
    .in_ready(in_ready),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data(out_data)
);

/* sim/exec_tb.sv */
`timescale 1ns/1ps

module exec_tb;

    localparam int n_fields = 11;
    localparam int max_ops = 40;
    localparam int wait_limit = 1000;

    logic clk;
    logic rst_n;
    logic flush;
    logic in_valid;
    logic in_ready;
    logic [exec_pkg::op_w-1:0] op;
    logic [exec_pkg::sel_w-1:0] sel_a;
    logic [exec_pkg::sel_w-1:0] sel_b;
    logic word;
    logic [exec_pkg::xlen-1:0] pc;
    logic [exec_pkg::xlen-1:0] rs1;
    logic [exec_pkg::xlen-1:0] rs2;
    logic [exec_pkg::xlen-1:0] csr;
    logic [exec_pkg::xlen-1:0] imm;
    logic out_valid;
    logic out_ready;
    logic [exec_pkg::xlen-1:0] out_data;

    // one row per operation, n_fields words each
    logic [63:0] td [0:n_fields*max_ops-1];
    logic [exec_pkg::xlen-1:0] exp_q [$];
    logic [exec_pkg::xlen-1:0] exp_val;
    logic [15:0] gap_lfsr;
    logic bp_en;
    int cycle;
    int n_checked;

    exec_unit_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    // consumer stalls, one lfsr bit per cycle
    initial begin
        logic [15:0] bp_lfsr;
        bp_lfsr = 16'd59069;
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (bp_en) begin
                out_ready = bp_lfsr[0];
                bp_lfsr = lfsr_step(bp_lfsr);
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            assert (exp_q.size() > 0) else begin
                report_failure("a result came out when no result was expected");
            end
            exp_val = exp_q.pop_front();
            assert (out_data == exp_val) else begin
                report_failure($sformatf("ERROR at %0t ns: result %0d is %h, expected %h",
                                         $time, n_checked, out_data, exp_val));
            end
            n_checked++;
        end
    end

    task automatic drive_entry(input int idx);
        int base;
        base = idx * n_fields;
        op = td[base][exec_pkg::op_w-1:0];
        sel_a = td[base+1][exec_pkg::sel_w-1:0];
        sel_b = td[base+2][exec_pkg::sel_w-1:0];
        word = td[base+3][0];
        pc = td[base+5];
        rs1 = td[base+6];
        rs2 = td[base+7];
        csr = td[base+8];
        imm = td[base+9];
        in_valid = 1'b1;
    endtask

    // starts and ends on a falling edge
    task automatic send_op(input int idx, input logic keep, output int t_acc);
        int n;
        drive_entry(idx);
        n = 0;
        @(posedge clk);
        while (!in_ready) begin
            n++;
            if (n > wait_limit) begin
                report_failure("timed out waiting for in_ready");
            end
            @(posedge clk);
        end
        t_acc = cycle;
        if (keep) begin
            exp_q.push_back(td[idx*n_fields+10]);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic drain_results(input string what);
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            n++;
            if (n > wait_limit) begin
                report_failure({"timed out waiting for ", what});
            end
            @(negedge clk);
        end
    endtask

    task automatic check_latency(input int idx);
        int t_in;
        int n;
        drain_results("results before the latency check");
        @(posedge clk);
        bp_en = 1'b0;
        @(negedge clk);
        send_op(idx, 1'b1, t_in);
        n = 0;
        @(posedge clk);
        while (!out_valid) begin
            n++;
            if (n > wait_limit) begin
                report_failure("timed out waiting for out_valid in the latency check");
            end
            @(posedge clk);
        end
        assert (cycle - t_in == 2) else begin
            report_failure($sformatf("ERROR at %0t ns: latency is %0d cycles, expected 2",
                                     $time, cycle - t_in));
        end
        bp_en = 1'b1;
        @(negedge clk);
    endtask

    // multiply busy and one item behind it, then a one-cycle flush
    task automatic flush_pipeline();
        int n;
        n = 0;
        @(posedge clk);
        while (in_ready) begin
            n++;
            if (n > wait_limit) begin
                report_failure("timed out waiting for the multiply to stall the input");
            end
            @(posedge clk);
        end
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    initial begin
        int idx;
        int t_acc;
        logic [63:0] flag;
        rst_n = 1'b0;
        flush = 1'b0;
        in_valid = 1'b0;
        op = '0;
        sel_a = '0;
        sel_b = '0;
        word = 1'b0;
        pc = '0;
        rs1 = '0;
        rs2 = '0;
        csr = '0;
        imm = '0;
        bp_en = 1'b1;
        gap_lfsr = 16'd59069;
        n_checked = 0;
        $readmemh("sim/exec_testdata.hex", td);
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        idx = 0;
        while (idx < max_ops && td[idx*n_fields+4] != 64'd3) begin
            flag = td[idx*n_fields+4];
            if (flag == 64'd2) begin
                check_latency(idx);
            end else if (flag == 64'd1) begin
                if (idx == 0 || td[(idx-1)*n_fields+4] != 64'd1) begin
                    drain_results("results before the flush test");
                end
                send_op(idx, 1'b0, t_acc);
                if (td[(idx+1)*n_fields+4] != 64'd1) begin
                    flush_pipeline();
                end
            end else begin
                if (gap_lfsr[0]) begin
                    @(negedge clk);
                end
                gap_lfsr = lfsr_step(gap_lfsr);
                send_op(idx, 1'b1, t_acc);
            end
            idx++;
        end
        drain_results("the last results");
        // a dropped multiply must not finish late
        repeat (exec_pkg::mul_steps + 8) @(negedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

/* sim/exec_testdata.hex */
// op sel_a sel_b word flag pc rs1 rs2 csr imm expected
// flag 0 checked, 1 dropped by flush, 2 latency check, 3 end of data
00 1 1 0 2 dead0000 0000000000000005 0000000000000003 c0c0 77 0000000000000008
01 1 1 0 0 dead0000 0000000000000000 0000000000000001 c0c0 77 ffffffffffffffff
02 2 1 0 0 0000000080001000 0000000000001234 0000000000000009 c0c0 77 0000000080001000
03 1 2 0 0 dead0000 0000000000001234 0000000000000009 0000000000c0ffee 77 0000000000c0ffee
03 1 3 0 0 dead0000 0000000000001234 0000000000000009 c0c0 fffffffffffff800 fffffffffffff800
04 1 1 0 0 dead0000 ff00ff00ff00ff00 0ff00ff00ff00ff0 c0c0 77 f0f0f0f0f0f0f0f0
05 1 1 0 0 dead0000 ff00ff00ff00ff00 0ff00ff00ff00ff0 c0c0 77 fff0fff0fff0fff0
06 1 1 0 0 dead0000 ff00ff00ff00ff00 0ff00ff00ff00ff0 c0c0 77 0f000f000f000f00
07 1 1 0 0 dead0000 0000000000000001 00000000000000ff c0c0 77 8000000000000000
08 1 1 0 0 dead0000 8000000000000001 0000000000000040 c0c0 77 8000000000000001
09 1 1 0 0 dead0000 8000000000000000 000000000000003f c0c0 77 ffffffffffffffff
0a 1 1 0 0 dead0000 8000000000000000 7fffffffffffffff c0c0 77 0000000000000001
0b 1 1 0 0 dead0000 8000000000000000 7fffffffffffffff c0c0 77 0000000000000000
0d 1 1 0 0 dead0000 ffffffffffffffff 0000000000000000 c0c0 77 0000000000000000
0e 1 1 0 0 dead0000 ffffffffffffffff 0000000000000000 c0c0 77 0000000000000001
0c 1 1 0 0 dead0000 123456789abcdef0 123456789abcdef0 c0c0 77 0000000000000001
00 1 1 1 0 dead0000 ffffffff00000005 0000000000000001 c0c0 77 0000000000000006
09 1 0 1 0 dead0000 1234567880000000 0000000000000009 c0c0 4 00000000f8000000
0f 1 1 0 0 dead0000 ffffffffffffffff ffffffffffffffff c0c0 77 0000000000000001
0f 1 1 0 0 dead0000 123456789abcdef0 0000000000000000 c0c0 77 0000000000000000
0f 1 1 0 0 dead0000 00000000ffffffff 00000000ffffffff c0c0 77 fffffffe00000001
00 1 1 0 0 dead0000 0000000000000010 0000000000000020 c0c0 77 0000000000000030
0f 1 1 0 1 dead0000 0000000000000003 0000000000000005 c0c0 77 000000000000000f
00 1 1 0 1 dead0000 0000000000000001 0000000000000001 c0c0 77 0000000000000002
01 1 1 0 0 dead0000 0000000000000064 0000000000000001 c0c0 77 0000000000000063
14 1 1 0 0 dead0000 ffffffffffffffff ffffffffffffffff c0c0 77 0000000000000000
00 0 0 0 3 0 0 0 0 0 0

/* tb.f */
hw/exec_pkg.sv
hw/exec_op_if.sv
hw/exec_mul_iter.sv
hw/exec_operand_sel.sv
hw/exec_alu.sv
hw/exec_result_buf.sv
hw/exec_unit_top.sv
sim/exec_checker.sv
sim/exec_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= exec_tb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
